// ==== hw/rom_loader_pkg.sv ====
// Address width, header layout constants, region names and the start table union.
package rom_loader_pkg;

    localparam int ADDR_W = 22;               // Download byte address and SDRAM word address.
    localparam int HEADER_BYTES = 32;         // The body starts right after this.
    localparam int START_FIRST = 8;           // First byte of the region start table.
    localparam int START_BYTES = 8;           // Four 16-bit start fields.
    localparam int BLOCK_W = ADDR_W - 8;      // Starts count 256-byte blocks.

    typedef logic [ADDR_W-1:0] prog_addr_t;

    // Region of the byte that is being downloaded, in address order.
    typedef enum logic [2:0] {
        region_cpu = 3'd0,
        region_snd = 3'd1,
        region_chr = 3'd2,
        region_scr = 3'd3,
        region_obj = 3'd4
    } region_e;

    // Field view of the start table. The last field sits in the low bits.
    typedef struct packed {
        logic [15:0] snd;
        logic [15:0] chr;
        logic [15:0] scr;
        logic [15:0] obj;
    } start_fields_t;

    // The parser fills the table byte by byte and the mapper reads the fields.
    typedef union packed {
        logic [START_BYTES-1:0][7:0] bytes;
        start_fields_t fields;
    } start_table_u;

endpackage

// ==== hw/region_map_if.sv ====
// Interface carrying the game configuration byte and the region start table.
`timescale 1ns/1ps

interface region_map_if
    import rom_loader_pkg::*;
();

    logic [7:0] cfg;             // Header byte 0.
    start_table_u starts;        // Header bytes 8 to 15.

    modport source (
        output cfg,
        output starts
    );

    modport user (
        input cfg,
        input starts
    );

endinterface

// ==== hw/prog_req_if.sv ====
// Interface carrying one SDRAM byte-lane write request and its accept pulse.
`timescale 1ns/1ps

interface prog_req_if
    import rom_loader_pkg::*;
();

    logic       valid;
    prog_addr_t addr;
    logic [7:0] data;
    logic [1:0] mask;            // Active low lane enables.
    logic       accept;

    modport source (
        output valid, addr, data, mask,
        input  accept
    );

    modport sink (
        input  valid, addr, data, mask,
        output accept
    );

endinterface

// ==== hw/rom_header_parser.sv ====
// ROM header parser that captures the configuration byte and the region start table.
`timescale 1ns/1ps

module rom_header_parser
    import rom_loader_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         downloading,
    input  prog_addr_t   ioctl_addr,
    input  logic [7:0]   ioctl_dout,
    input  logic         ioctl_wr,
    region_map_if.source map
);

    logic [7:0]   cfg_q;
    start_table_u starts_q;
    logic         byte_strobe;
    logic         is_cfg;
    logic         is_start;

    assign byte_strobe = ioctl_wr && downloading;
    assign is_cfg = ioctl_addr == '0;
    assign is_start = ioctl_addr >= prog_addr_t'(START_FIRST) &&
                      ioctl_addr < prog_addr_t'(START_FIRST + START_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
            starts_q <= '0;
        end else if (byte_strobe) begin
            if (is_cfg) begin
                cfg_q <= ioctl_dout;
            end
            if (is_start) begin
                // Byte 8 is shifted up until byte 15 lands in the low position.
                starts_q.bytes <= {starts_q.bytes[START_BYTES-2:0], ioctl_dout};
            end
        end
    end

    assign map.cfg = cfg_q;
    assign map.starts = starts_q;

endmodule

// ==== hw/rom_region_mapper.sv ====
// Region classifier and direct write address former for the ROM body bytes.
`timescale 1ns/1ps

module rom_region_mapper
    import rom_loader_pkg::*;
#(
    parameter prog_addr_t CPU_OFFSET  = '0,
    parameter prog_addr_t SND_OFFSET  = '0,
    parameter prog_addr_t CHAR_OFFSET = '0,
    parameter prog_addr_t OBJ_OFFSET  = '0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         downloading,
    input  prog_addr_t   ioctl_addr,
    input  logic [7:0]   ioctl_dout,
    input  logic         ioctl_wr,
    region_map_if.user   map,
    prog_req_if.source   req,
    output logic         scr_byte,
    output logic [7:0]   scr_data,
    output logic         body_other
);

    logic [BLOCK_W-1:0] snd_start;
    logic [BLOCK_W-1:0] chr_start;
    logic [BLOCK_W-1:0] scr_start;
    logic [BLOCK_W-1:0] obj_start;
    prog_addr_t         body;
    prog_addr_t         snd_rel;
    prog_addr_t         chr_rel;
    prog_addr_t         obj_rel;
    logic [BLOCK_W-1:0] blk;
    logic               is_body;
    logic               body_strobe;
    region_e            region;
    prog_addr_t         direct_addr;
    logic [1:0]         direct_mask;

    assign snd_start = map.starts.fields.snd[BLOCK_W-1:0];
    assign chr_start = map.starts.fields.chr[BLOCK_W-1:0];
    assign scr_start = map.starts.fields.scr[BLOCK_W-1:0];
    assign obj_start = map.starts.fields.obj[BLOCK_W-1:0];

    assign body = ioctl_addr - prog_addr_t'(HEADER_BYTES);    // Offset past the header.
    assign snd_rel = body - {snd_start, 8'd0};
    assign chr_rel = body - {chr_start, 8'd0};
    assign obj_rel = body - {obj_start, 8'd0};
    assign blk = body[ADDR_W-1:8];

    assign is_body = ioctl_addr >= prog_addr_t'(HEADER_BYTES);
    assign body_strobe = ioctl_wr && downloading && is_body;

    // Regions follow each other, so the first start above the block wins.
    always_comb begin
        if (blk < snd_start) begin
            region = region_cpu;
        end else if (blk < chr_start) begin
            region = region_snd;
        end else if (blk < scr_start) begin
            region = region_chr;
        end else if (blk < obj_start) begin
            region = region_scr;
        end else begin
            region = region_obj;
        end
    end

    always_comb begin
        case (region)
            region_snd: direct_addr = {1'b0, snd_rel[ADDR_W-1:1]} + SND_OFFSET;
            region_chr: direct_addr = {1'b0, chr_rel[ADDR_W-1:1]} + CHAR_OFFSET;
            region_obj: direct_addr = {1'b0, obj_rel[ADDR_W-1:7], obj_rel[5:2],
                                       obj_rel[6], obj_rel[1]} + OBJ_OFFSET;
            default:    direct_addr = {1'b0, body[ADDR_W-1:1]} + CPU_OFFSET;
        endcase
        // CPU and sound put even bytes low, graphics put them high.
        if (body[0] ^ (region == region_cpu || region == region_snd)) begin
            direct_mask = 2'b10;
        end else begin
            direct_mask = 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
            scr_byte <= 1'b0;
            body_other <= 1'b0;
        end else begin
            req.valid <= body_strobe && region != region_scr;    // Single-cycle pulse.
            scr_byte <= body_strobe && region == region_scr;
            body_other <= body_strobe && region != region_scr;
        end
    end

    always_ff @(posedge clk) begin
        if (body_strobe) begin
            req.addr <= direct_addr;
            req.data <= ioctl_dout;
            req.mask <= direct_mask;
            scr_data <= ioctl_dout;
        end
    end

endmodule

// ==== hw/scroll_nibble_packer.sv ====
// Scroll byte collector that rewrites each group of four bytes as nibble-packed writes.
`timescale 1ns/1ps

module scroll_nibble_packer
    import rom_loader_pkg::*;
#(
    parameter prog_addr_t SCR_OFFSET = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       scr_byte,
    input  logic [7:0] scr_data,
    input  logic       body_other,
    prog_req_if.source req
);

    logic [23:0] collect;        // Bytes b2, b1 and b0 of the group being filled.
    logic [31:0] group;          // The full group b3 to b0 being written out.
    logic [1:0]  fill;
    logic [1:0]  step;           // Which of the four rewrites is offered.
    logic        valid_q;
    prog_addr_t  scr_addr;

    always_ff @(posedge clk) begin
        if (scr_byte) begin
            collect <= {scr_data, collect[23:8]};
            if (fill == 2'd3) begin
                group <= {scr_data, collect};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill <= '0;
            step <= '0;
            valid_q <= 1'b0;
            scr_addr <= SCR_OFFSET;
        end else begin
            if (req.accept) begin
                step <= step + 2'd1;
                if (step == 2'd3) begin
                    valid_q <= 1'b0;
                    scr_addr <= scr_addr + prog_addr_t'(2);    // Two words per group.
                end
            end
            if (scr_byte) begin
                fill <= fill + 2'd1;
                if (fill == 2'd3) begin
                    valid_q <= 1'b1;
                    step <= '0;
                end
            end
            if (body_other) begin
                fill <= '0;
                scr_addr <= SCR_OFFSET;    // Leaving the scroll region restarts it.
            end
        end
    end

    assign req.valid = valid_q;
    assign req.addr = scr_addr + prog_addr_t'(step[1]);
    assign req.mask = step[0] ? 2'b01 : 2'b10;

    // High nibbles go to word A and low nibbles to word A+1.
    always_comb begin
        case (step)
            2'd0:    req.data = {group[15:12], group[7:4]};
            2'd1:    req.data = {group[31:28], group[23:20]};
            2'd2:    req.data = {group[11:8], group[3:0]};
            default: req.data = {group[27:24], group[19:16]};
        endcase
    end

endmodule

// ==== hw/prog_write_port.sv ====
// SDRAM write port that arbitrates direct and scroll requests and holds the write enable.
`timescale 1ns/1ps

module prog_write_port
    import rom_loader_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       downloading,
    input  logic       ioctl_wr,
    input  logic       sdram_ack,
    prog_req_if.sink   direct,
    prog_req_if.sink   scroll,
    output prog_addr_t prog_addr,
    output logic [7:0] prog_data,
    output logic [1:0] prog_mask,    // Active low.
    output logic       prog_we
);

    logic take_scroll;

    // Scroll rewrites only fill idle slots between host bytes.
    assign take_scroll = scroll.valid && !prog_we && !ioctl_wr && downloading &&
                         !direct.valid;
    assign scroll.accept = take_scroll;
    assign direct.accept = direct.valid;    // A direct request is never refused.

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (!downloading) begin
            prog_we <= 1'b0;
        end else if (direct.valid) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;
        end else if (take_scroll) begin
            prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (direct.valid) begin
            prog_addr <= direct.addr;    // Overrides a scroll write in flight.
            prog_data <= direct.data;
            prog_mask <= direct.mask;
        end else if (take_scroll) begin
            prog_addr <= scroll.addr;
            prog_data <= scroll.data;
            prog_mask <= scroll.mask;
        end
    end

endmodule

// ==== hw/rom_download_loader.sv ====
// Top level of the ROM download preprocessor with header parser, mapper, packer and write port.
`timescale 1ns/1ps

module rom_download_loader
    import rom_loader_pkg::*;
#(
    parameter prog_addr_t CPU_OFFSET  = '0,
    parameter prog_addr_t SND_OFFSET  = '0,
    parameter prog_addr_t CHAR_OFFSET = '0,
    parameter prog_addr_t OBJ_OFFSET  = '0,
    parameter prog_addr_t SCR_OFFSET  = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       downloading,
    input  prog_addr_t ioctl_addr,
    input  logic [7:0] ioctl_dout,
    input  logic       ioctl_wr,
    input  logic       sdram_ack,
    output prog_addr_t prog_addr,
    output logic [7:0] prog_data,
    output logic [1:0] prog_mask,
    output logic       prog_we,
    output logic [7:0] game_cfg
);

    logic       scr_byte;
    logic [7:0] scr_data;
    logic       body_other;

    region_map_if map ();
    prog_req_if   direct_req ();
    prog_req_if   scroll_req ();

    rom_header_parser u_parser (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .map         (map.source)
    );

    rom_region_mapper #(
        .CPU_OFFSET  (CPU_OFFSET),
        .SND_OFFSET  (SND_OFFSET),
        .CHAR_OFFSET (CHAR_OFFSET),
        .OBJ_OFFSET  (OBJ_OFFSET)
    ) u_mapper (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .map         (map.user),
        .req         (direct_req.source),
        .scr_byte    (scr_byte),
        .scr_data    (scr_data),
        .body_other  (body_other)
    );

    scroll_nibble_packer #(
        .SCR_OFFSET (SCR_OFFSET)
    ) u_packer (
        .clk        (clk),
        .reset      (reset),
        .scr_byte   (scr_byte),
        .scr_data   (scr_data),
        .body_other (body_other),
        .req        (scroll_req.source)
    );

    prog_write_port u_write_port (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .direct      (direct_req.sink),
        .scroll      (scroll_req.sink),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we)
    );

    assign game_cfg = map.cfg;    // Header byte 0 goes straight to the game.

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset generator.
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;          // Released just after the eighth edge.
    end

endmodule

// ==== testbench/rom_download_loader_assertions.sv ====
// Concurrent assertions on the SDRAM write outputs of the ROM download loader and their bind.
`timescale 1ns/1ps

module rom_download_loader_assertions (
    input logic       clk,
    input logic       reset,
    input logic       downloading,
    input logic       sdram_ack,
    input logic       prog_we,
    input logic [1:0] prog_mask
);

    // The reset is synchronous, so the enable is low from the edge after it.
    we_low_in_reset: assert property (@(posedge clk) reset |=> !prog_we)
        else $error("prog_we is high while reset is asserted");

    one_lane: assert property (@(posedge clk) disable iff (reset)
        prog_we |-> (prog_mask == 2'b10 || prog_mask == 2'b01))
        else $error("prog_we is high with lane mask %b", prog_mask);

    we_held: assert property (@(posedge clk) disable iff (reset)
        prog_we && !sdram_ack && downloading |=> prog_we)
        else $error("prog_we dropped without sdram_ack while downloading");

endmodule

bind rom_download_loader rom_download_loader_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .downloading (downloading),
    .sdram_ack   (sdram_ack),
    .prog_we     (prog_we),
    .prog_mask   (prog_mask)
);

// ==== testbench/tb_rom_download_loader.sv ====
// Testbench for the ROM download loader with directed tests and an SDRAM acknowledge model.
`timescale 1ns/1ps

module tb_rom_download_loader
    import rom_loader_pkg::*;
();

    localparam prog_addr_t CPU_OFF = 22'h000100;
    localparam prog_addr_t SND_OFF = 22'h020000;
    localparam prog_addr_t CHR_OFF = 22'h040000;
    localparam prog_addr_t OBJ_OFF = 22'h080000;
    localparam prog_addr_t SCR_OFF = 22'h100000;
    localparam int SND_BODY = 'h400;    // Region starts of the test header, in body bytes.
    localparam int CHR_BODY = 'h800;
    localparam int SCR_BODY = 'hC00;
    localparam int OBJ_BODY = 'h1000;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        reset;
    logic        downloading;
    prog_addr_t  ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        sdram_ack;
    prog_addr_t  prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic [7:0]  game_cfg;
    logic        ack_enable;
    logic [15:0] lfsr = 16'd13431;
    prog_addr_t  log_addr[$];
    logic [7:0]  log_data[$];
    logic [1:0]  log_mask[$];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rom_download_loader #(
        .CPU_OFFSET  (CPU_OFF),
        .SND_OFFSET  (SND_OFF),
        .CHAR_OFFSET (CHR_OFF),
        .OBJ_OFFSET  (OBJ_OFF),
        .SCR_OFFSET  (SCR_OFF)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .game_cfg    (game_cfg)
    );

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);    // Galois step.
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s.", $time, what);
        $display("Simulation failed");
        $fatal(1, "Stopped on a timeout.");
    endtask

    // The SDRAM model logs every new write and acknowledges it after 1 to 8 cycles.
    initial begin : sdram_model
        logic was_we;
        int   delay;
        sdram_ack = 1'b0;
        was_we = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (prog_we && !was_we) begin
                log_addr.push_back(prog_addr);
                log_data.push_back(prog_data);
                log_mask.push_back(prog_mask);
                if (ack_enable) begin
                    delay = 1 + random_bits(3);
                    repeat (delay - 1) begin
                        @(posedge clk);
                        #1;
                    end
                    sdram_ack = 1'b1;
                    @(posedge clk);
                    #1;
                    sdram_ack = 1'b0;
                end
            end
            was_we = prog_we;
        end
    end

    task automatic send_byte(input int addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        ioctl_addr = prog_addr_t'(addr);
        ioctl_dout = data;
        ioctl_wr = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_writes(input int count);
        int cycles;
        cycles = 0;
        while (log_addr.size() < count || prog_we || sdram_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("the SDRAM writes to finish");
        end
    endtask

    task automatic check_next(input prog_addr_t addr, input logic [7:0] data,
                              input logic [1:0] mask);
        check_value("prog_addr", 32'(log_addr.pop_front()), 32'(addr));
        check_value("prog_data", 32'(log_data.pop_front()), 32'(data));
        check_value("prog_mask", 32'(log_mask.pop_front()), 32'(mask));
    endtask

    // Expected word address and active-low lane mask of a body byte.
    task automatic expect_direct(input int body, output prog_addr_t addr,
                                 output logic [1:0] mask);
        int   rel;
        logic low_lane;
        low_lane = (body % 2) == 0;
        if (body < SND_BODY) begin
            addr = prog_addr_t'(body / 2) + CPU_OFF;
        end else if (body < CHR_BODY) begin
            addr = prog_addr_t'((body - SND_BODY) / 2) + SND_OFF;
        end else if (body < SCR_BODY) begin
            addr = prog_addr_t'((body - CHR_BODY) / 2) + CHR_OFF;
            low_lane = !low_lane;
        end else begin
            rel = body - OBJ_BODY;
            addr = prog_addr_t'((rel / 128) * 64 + ((rel / 4) % 16) * 4 +
                                ((rel / 64) % 2) * 2 + (rel / 2) % 2) + OBJ_OFF;
            low_lane = !low_lane;
        end
        mask = low_lane ? 2'b10 : 2'b01;
    endtask

    task automatic direct_byte(input int body);
        logic [7:0] data;
        prog_addr_t addr;
        logic [1:0] mask;
        data = 8'(random_bits(8));
        send_byte(body + HEADER_BYTES, data);
        wait_writes(1);
        expect_direct(body, addr, mask);
        check_next(addr, data, mask);
    endtask

    // Start fields go sound, character, scroll, object, each high byte first.
    task automatic send_header(input logic [7:0] cfg);
        logic [7:0] hdr [HEADER_BYTES];
        for (int i = 0; i < HEADER_BYTES; i++) hdr[i] = 8'(random_bits(8));
        hdr[0] = cfg;
        hdr[8] = 8'd0;
        hdr[9] = 8'(SND_BODY / 256);
        hdr[10] = 8'd0;
        hdr[11] = 8'(CHR_BODY / 256);
        hdr[12] = 8'd0;
        hdr[13] = 8'(SCR_BODY / 256);
        hdr[14] = 8'd0;
        hdr[15] = 8'(OBJ_BODY / 256);
        for (int i = 0; i < HEADER_BYTES; i++) send_byte(i, hdr[i]);
        repeat (4) @(negedge clk);
        check_value("header write count", 32'(log_addr.size()), 32'd0);
        check_value("game_cfg", 32'(game_cfg), 32'(cfg));
    endtask

    task automatic scroll_group(input int body, input prog_addr_t base);
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'(random_bits(8));
            send_byte(body + i + HEADER_BYTES, b[i]);
        end
        wait_writes(4);
        check_next(base, {b[1][7:4], b[0][7:4]}, 2'b10);    // High nibbles to word A.
        check_next(base, {b[3][7:4], b[2][7:4]}, 2'b01);
        check_next(base + 22'd1, {b[1][3:0], b[0][3:0]}, 2'b10);
        check_next(base + 22'd1, {b[3][3:0], b[2][3:0]}, 2'b01);
    endtask

    task automatic test_cpu_sound();
        int bodies [9] = '{0, 1, 2, 3, 'h1FF, 'h400, 'h401, 'h402, 'h7FF};
        foreach (bodies[i]) direct_byte(bodies[i]);
    endtask

    task automatic test_graphics();
        int bodies [8] = '{'h800, 'h801, 'hBFE, 'h1000, 'h1001, 'h10C6, 'h1357, 'h2F9B};
        foreach (bodies[i]) direct_byte(bodies[i]);
    endtask

    task automatic test_scroll();
        scroll_group(SCR_BODY, SCR_OFF);
        scroll_group(SCR_BODY + 4, SCR_OFF + 22'd2);
        direct_byte(OBJ_BODY + 8);
        scroll_group(SCR_BODY + 8, SCR_OFF);
        @(posedge clk);
        #1 downloading = 1'b0;    // A fresh download restarts the scroll words too.
        @(posedge clk);
        #1 downloading = 1'b1;
        send_header(8'h5A);
        direct_byte(6);
        scroll_group(SCR_BODY + 4, SCR_OFF);
        scroll_group(SCR_BODY + 8, SCR_OFF + 22'd2);
    endtask

    task automatic test_abort();
        int         cycles;
        prog_addr_t addr;
        logic [1:0] mask;
        ack_enable = 1'b0;
        send_byte(HEADER_BYTES + 10, 8'h3C);
        cycles = 0;
        while (!prog_we) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("prog_we to rise");
        end
        @(posedge clk);
        #1 downloading = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("prog_we", 32'(prog_we), 32'd0);
        expect_direct(10, addr, mask);
        check_next(addr, 8'h3C, mask);
        send_byte(HEADER_BYTES + 12, 8'h77);
        repeat (6) @(negedge clk);
        check_value("prog_we", 32'(prog_we), 32'd0);
        check_value("write count after abort", 32'(log_addr.size()), 32'd0);
        ack_enable = 1'b1;
    endtask

    initial begin : main
        int cycles;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        ack_enable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("the reset to end");
        end
        @(posedge clk);
        #1 downloading = 1'b1;
        send_header(8'(random_bits(8)));
        test_cpu_sound();
        test_graphics();
        test_scroll();
        test_abort();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== build.f ====
hw/rom_loader_pkg.sv
hw/region_map_if.sv
hw/prog_req_if.sv
hw/rom_header_parser.sv
hw/rom_region_mapper.sv
hw/scroll_nibble_packer.sv
hw/prog_write_port.sv
hw/rom_download_loader.sv
testbench/tb_clock_gen.sv
testbench/rom_download_loader_assertions.sv
testbench/tb_rom_download_loader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rom_download_loader
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
